/* filelist.f */
+incdir+.
mem_tile_pkg.sv
sram_macro.sv
mem_bank_column.sv
mem_req_split.sv
mem_rsp_merge.sv
mem_tile_top.sv
tb_clk_gen.sv
tb_mem_tile.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the memory tile testbench with Verilator, run it and check the log

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=sim_mem_tile
log_file=sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_mem_tile \
  -f filelist.f \
  --Mdir "$build_dir" \
  -o "$sim_bin"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" "$log_file"; then
  exit 0
else
  echo "Pass message not found in $log_file"
  exit 1
fi

/* tb_mem_tile.sv */
// Memory tile testbench
// Random reads and writes against a byte-level reference model, each
// response checked at exactly two cycles after its request

`timescale 1ns/1ps
`default_nettype none

`include "mem_tile_config.svh"

module tb_mem_tile;

  localparam int unsigned word_bytes  = `MEM_NUM_LANES * `MEM_LANE_WIDTH / 8;
  localparam int unsigned num_words   = `MEM_NUM_ROWS * `MEM_ROW_WORDS;
  localparam int unsigned mem_bytes   = num_words * word_bytes;
  localparam int unsigned rsp_delay   = 2;
  localparam int unsigned drain_limit = 20;

  logic                       clk;
  logic                       arst_n;
  logic                       req;
  logic                       we;
  logic [`MEM_ADDR_WIDTH-1:0] addr;
  logic [word_bytes*8-1:0]    wdata;
  logic [word_bytes-1:0]      be;
  logic                       rvalid;
  logic [word_bytes*8-1:0]    rdata;
  logic                       err;

  string       test_name;
  string       req_tag;
  int unsigned edge_cnt = 0;
  int unsigned value_errs = 0;
  int unsigned proto_errs = 0;
  int unsigned rsp_cnt = 0;

  logic [7:0] model_mem [mem_bytes];

  // Expected responses, oldest first
  int unsigned                exp_due_q  [$];
  logic [word_bytes*8-1:0]    exp_data_q [$];
  logic                       exp_err_q  [$];
  logic [`MEM_ADDR_WIDTH-1:0] exp_addr_q [$];
  string                      exp_tag_q  [$];

  tb_clk_gen #(.period_ns_p(20)) u_clk_gen (.clk_o(clk));

  mem_tile_top u_dut (
    .clk_i   (clk),
    .arst_n_i(arst_n),
    .req_i   (req),
    .we_i    (we),
    .addr_i  (addr),
    .wdata_i (wdata),
    .be_i    (be),
    .rvalid_o(rvalid),
    .rdata_o (rdata),
    .err_o   (err)
  );

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  ////////////////////////////////////////////////////////////////////////
  // Reference model and response checks
  ////////////////////////////////////////////////////////////////////////

  // Inputs seen at a falling edge are taken at the next rising edge
  task automatic push_expected(input logic [word_bytes*8-1:0] data, input logic err_flag);
    exp_due_q.push_back(edge_cnt + 1 + rsp_delay);
    exp_data_q.push_back(data);
    exp_err_q.push_back(err_flag);
    exp_addr_q.push_back(addr);
    exp_tag_q.push_back(req_tag);
  endtask

  task automatic record_request();
    int unsigned             base;
    logic [word_bytes*8-1:0] word;
    if (arst_n && req) begin
      if (addr < mem_bytes) begin
        base = (addr / word_bytes) * word_bytes;
        if (we) begin
          for (int b = 0; b < word_bytes; b++) begin
            if (be[b]) begin
              model_mem[base + b] = wdata[b*8 +: 8];
            end
          end
        end else begin
          for (int b = 0; b < word_bytes; b++) begin
            word[b*8 +: 8] = model_mem[base + b];
          end
          push_expected(word, 1'b0);
        end
      end else if (!we) begin
        push_expected('0, 1'b1);
      end
    end
  endtask

  task automatic check_response();
    int unsigned                due;
    int unsigned                sample_edge;
    logic [word_bytes*8-1:0]    exp_data;
    logic                       exp_err;
    logic [`MEM_ADDR_WIDTH-1:0] exp_addr;
    string                      tag;
    // Outputs seen at a falling edge are sampled at the next rising edge
    sample_edge = edge_cnt + 1;
    if (rvalid === 1'b1) begin
      if (exp_due_q.size() == 0) begin
        $display("Unexpected response at cycle %0d with no read outstanding", sample_edge);
        proto_errs++;
      end else begin
        due      = exp_due_q.pop_front();
        exp_data = exp_data_q.pop_front();
        exp_err  = exp_err_q.pop_front();
        exp_addr = exp_addr_q.pop_front();
        tag      = exp_tag_q.pop_front();
        rsp_cnt++;
        if (due != sample_edge) begin
          $display("[%s] response for address %h came at cycle %0d, due at cycle %0d",
                   tag, exp_addr, sample_edge, due);
          proto_errs++;
        end
        if (err !== exp_err) begin
          $display("ERR %s addr=%h err_o expected %0b actual %0b", tag, exp_addr, exp_err, err);
          value_errs++;
        end
        if (rdata !== exp_data) begin
          $display("ERR %s addr=%h rdata_o expected %h actual %h",
                   tag, exp_addr, exp_data, rdata);
          value_errs++;
        end
      end
    end else begin
      if (err !== 1'b0) begin
        $display("err_o is not low without rvalid_o at cycle %0d", sample_edge);
        proto_errs++;
      end
      if (exp_due_q.size() != 0 && exp_due_q[0] <= sample_edge) begin
        $display("[%s] no response for address %h due at cycle %0d",
                 exp_tag_q[0], exp_addr_q[0], exp_due_q[0]);
        proto_errs++;
        void'(exp_due_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_err_q.pop_front());
        void'(exp_addr_q.pop_front());
        void'(exp_tag_q.pop_front());
      end
    end
  endtask

  // Check before recording so a new read never meets its own cycle
  always @(negedge clk) begin
    check_response();
    record_request();
  end

  ////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////

  task automatic drive_req(input logic wr, input logic [`MEM_ADDR_WIDTH-1:0] a,
                           input logic [word_bytes*8-1:0] d, input logic [word_bytes-1:0] en);
    @(posedge clk);
    req     <= 1'b1;
    we      <= wr;
    addr    <= a;
    wdata   <= d;
    be      <= en;
    req_tag <= test_name;
  endtask

  task automatic drive_idle();
    @(posedge clk);
    req <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic check_outputs_low(input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (rvalid !== 1'b0 || err !== 1'b0 || rdata !== '0) begin
        $display("ERR %s rvalid/err/rdata expected 0/0/%h actual %0b/%0b/%h",
                 test_name, {word_bytes*8{1'b0}}, rvalid, err, rdata);
        value_errs++;
      end
    end
  endtask

  function automatic logic [word_bytes*8-1:0] random_word();
    return {$urandom, $urandom};
  endfunction

  function automatic logic [word_bytes-1:0] random_be();
    int unsigned r;
    r = $urandom;
    return r[word_bytes-1:0];
  endfunction

  function automatic logic [`MEM_ADDR_WIDTH-1:0] pick_in_range();
    int unsigned r;
    r = $urandom_range(mem_bytes - 1, 0);
    return r[`MEM_ADDR_WIDTH-1:0];
  endfunction

  function automatic logic [`MEM_ADDR_WIDTH-1:0] pick_out_of_range();
    int unsigned r;
    r = $urandom_range(2 ** `MEM_ADDR_WIDTH - 1, mem_bytes);
    return r[`MEM_ADDR_WIDTH-1:0];
  endfunction

  // Byte address of a word plus a random offset, which the DUT ignores
  function automatic logic [`MEM_ADDR_WIDTH-1:0] word_addr(input int unsigned w);
    int unsigned r;
    r = w * word_bytes + $urandom_range(word_bytes - 1, 0);
    return r[`MEM_ADDR_WIDTH-1:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned                sel;
    int unsigned                wait_cnt;
    logic [`MEM_ADDR_WIDTH-1:0] a;
    void'($urandom(32'h6446));
    arst_n    = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    wdata     = '0;
    be        = '0;
    req_tag   = "reset";
    test_name = "idle_reset";
    check_outputs_low(16);
    @(posedge clk);
    arst_n <= 1'b1;
    test_name = "idle_after_reset";
    check_outputs_low(8);

    test_name = "fill_readback";
    for (int w = 0; w < num_words; w++) begin
      drive_req(1'b1, word_addr(w), random_word(), '1);
    end
    for (int w = 0; w < num_words; w++) begin
      drive_req(1'b0, word_addr(w), '0, '0);
    end
    drive_idle();

    test_name = "partial_be";
    repeat (128) begin
      drive_req(1'b1, pick_in_range(), random_word(), random_be());
    end
    for (int w = 0; w < num_words; w++) begin
      drive_req(1'b0, word_addr(w), '0, '0);
    end
    drive_idle();

    test_name = "back_to_back";
    repeat (64) begin
      drive_req(1'b0, pick_in_range(), '0, '0);
    end
    drive_idle();

    test_name = "write_then_read";
    repeat (32) begin
      a = pick_in_range();
      drive_req(1'b1, a, random_word(), random_be());
      drive_req(1'b0, a, '0, '0);
    end
    drive_idle();

    test_name = "random_mix";
    for (int c = 0; c < 400; c++) begin
      sel = $urandom_range(9, 0);
      if (sel < 2) begin
        drive_idle();
      end else if (sel < 5) begin
        drive_req(1'b0, pick_in_range(), '0, '0);
      end else if (sel < 8) begin
        drive_req(1'b1, pick_in_range(), random_word(), random_be());
      end else if (sel == 8) begin
        drive_req(1'b0, pick_out_of_range(), '0, '0);
      end else begin
        drive_req(1'b1, pick_out_of_range(), random_word(), '1);
      end
    end
    drive_idle();

    wait_cnt = 0;
    while (exp_due_q.size() != 0 && wait_cnt < drain_limit) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (exp_due_q.size() != 0) begin
      $display("Timeout: %0d responses still outstanding after %0d cycles",
               exp_due_q.size(), drain_limit);
      proto_errs++;
    end
    @(negedge clk);

    $display("Responses checked %0d, value errors %0d, protocol errors %0d",
             rsp_cnt, value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// Testbench clock generator
// Free-running clock, starts low

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned period_ns_p = 20
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(period_ns_p / 2) clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

/* mem_tile_top.sv */
// Memory tile top level
// Banked SRAM reached through plain request strobes: the splitter
// feeds a generate loop of lane columns, the merger returns read data
// two cycles after the request

`timescale 1ns/1ps
`default_nettype none

`include "mem_tile_config.svh"

module mem_tile_top (
  input  wire logic                                  clk_i,
  input  wire logic                                  arst_n_i,
  input  wire logic                                  req_i,
  input  wire logic                                  we_i,
  input  wire logic [`MEM_ADDR_WIDTH-1:0]            addr_i,
  input  wire logic [mem_tile_pkg::word_width-1:0]   wdata_i,
  input  wire logic [mem_tile_pkg::word_width/8-1:0] be_i,
  output logic                                       rvalid_o,
  output logic      [mem_tile_pkg::word_width-1:0]   rdata_o,
  output logic                                       err_o
);

  logic                                    lane_req;
  logic                                    lane_we;
  logic [mem_tile_pkg::sel_width-1:0]      row_sel;
  logic [mem_tile_pkg::row_addr_width-1:0] row_addr;
  logic [`MEM_LANE_WIDTH-1:0]              lane_wdata [`MEM_NUM_LANES];
  logic [mem_tile_pkg::lane_be_width-1:0]  lane_be [`MEM_NUM_LANES];
  logic [`MEM_LANE_WIDTH-1:0]              lane_rdata [`MEM_NUM_LANES];
  logic                                    rd_acc;
  logic                                    rd_err;

  //////////////////////////////////////////////////////////////////////
  // Request decode
  //////////////////////////////////////////////////////////////////////

  mem_req_split i_req_split (
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .be_i        (be_i),
    .lane_req_o  (lane_req),
    .lane_we_o   (lane_we),
    .row_sel_o   (row_sel),
    .row_addr_o  (row_addr),
    .lane_wdata_o(lane_wdata),
    .lane_be_o   (lane_be),
    .rd_acc_o    (rd_acc),
    .rd_err_o    (rd_err)
  );

  //////////////////////////////////////////////////////////////////////
  // Lane columns
  //////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < `MEM_NUM_LANES; l++) begin : gen_columns
    mem_bank_column i_column (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .req_i     (lane_req),
      .we_i      (lane_we),
      .row_sel_i (row_sel),
      .row_addr_i(row_addr),
      .wdata_i   (lane_wdata[l]),
      .be_i      (lane_be[l]),
      .rdata_o   (lane_rdata[l])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////////////////////////

  mem_rsp_merge i_rsp_merge (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .rd_acc_i    (rd_acc),
    .rd_err_i    (rd_err),
    .lane_rdata_i(lane_rdata),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .err_o       (err_o)
  );

endmodule

`default_nettype wire

/* mem_rsp_merge.sv */
// Response merger
// Joins the lane read data into one word and registers the response,
// with its valid and error flags, one cycle after the lane data

`timescale 1ns/1ps
`default_nettype none

`include "mem_tile_config.svh"

module mem_rsp_merge (
  input  wire logic                                clk_i,
  input  wire logic                                arst_n_i,
  input  wire logic                                rd_acc_i,
  input  wire logic                                rd_err_i,
  input  wire logic [`MEM_LANE_WIDTH-1:0]          lane_rdata_i [`MEM_NUM_LANES],
  output logic                                     rvalid_o,
  output logic      [mem_tile_pkg::word_width-1:0] rdata_o,
  output logic                                     err_o
);

  logic [mem_tile_pkg::word_width-1:0] joined_rdata;
  logic                                rd_acc_q;
  logic                                rd_err_q;

  for (genvar l = 0; l < `MEM_NUM_LANES; l++) begin : gen_join
    assign joined_rdata[l*`MEM_LANE_WIDTH +: `MEM_LANE_WIDTH] = lane_rdata_i[l];
  end

  // Flags wait one stage for the macro output register
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_acc_q <= 1'b0;
      rd_err_q <= 1'b0;
    end else begin
      rd_acc_q <= rd_acc_i;
      rd_err_q <= rd_err_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response cut
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rvalid_o <= rd_acc_q || rd_err_q;
      err_o    <= rd_err_q;
      if (rd_acc_q) begin
        rdata_o <= joined_rdata;
      end else if (rd_err_q) begin
        // error responses carry no data
        rdata_o <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* mem_req_split.sv */
// Request splitter
// Decodes the byte address into macro select and row address, checks
// it against the memory range and slices write data and byte enables
// per lane, lane 0 in the low bits

`timescale 1ns/1ps
`default_nettype none

`include "mem_tile_config.svh"

module mem_req_split (
  input  wire logic                                    req_i,
  input  wire logic                                    we_i,
  input  wire logic [`MEM_ADDR_WIDTH-1:0]              addr_i,
  input  wire logic [mem_tile_pkg::word_width-1:0]     wdata_i,
  input  wire logic [mem_tile_pkg::word_width/8-1:0]   be_i,
  output logic                                         lane_req_o,
  output logic                                         lane_we_o,
  output logic      [mem_tile_pkg::sel_width-1:0]      row_sel_o,
  output logic      [mem_tile_pkg::row_addr_width-1:0] row_addr_o,
  output logic      [`MEM_LANE_WIDTH-1:0]              lane_wdata_o [`MEM_NUM_LANES],
  output logic      [mem_tile_pkg::lane_be_width-1:0]  lane_be_o [`MEM_NUM_LANES],
  output logic                                         rd_acc_o,
  output logic                                         rd_err_o
);

  // First byte past the end of the memory
  localparam logic [`MEM_ADDR_WIDTH-1:0] mem_bytes = `MEM_ADDR_WIDTH'(
      `MEM_NUM_ROWS * `MEM_ROW_WORDS * (mem_tile_pkg::word_width / 8));

  mem_tile_pkg::mem_addr_u addr_u;
  logic                    in_range;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  assign addr_u   = addr_i;
  assign in_range = (addr_u.flat < mem_bytes);

  assign row_sel_o  = addr_u.fields.macro_sel;
  assign row_addr_o = addr_u.fields.row_addr;

  // Out-of-range requests never reach the columns
  assign lane_req_o = req_i && in_range;
  assign lane_we_o  = req_i && in_range && we_i;

  assign rd_acc_o = req_i && !we_i && in_range;
  assign rd_err_o = req_i && !we_i && !in_range;

  //////////////////////////////////////////////////////////////////////
  // Lane slicing
  //////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < `MEM_NUM_LANES; l++) begin : gen_lanes
    assign lane_wdata_o[l] = wdata_i[l*`MEM_LANE_WIDTH +: `MEM_LANE_WIDTH];
    assign lane_be_o[l]    = be_i[l*mem_tile_pkg::lane_be_width +: mem_tile_pkg::lane_be_width];
  end

endmodule

`default_nettype wire

/* mem_bank_column.sv */
// Memory bank column
// One lane of the data word: a row of SRAM macros, of which the
// decoded macro select enables one, and the read-data selection
// driven by the select registered with each read

`timescale 1ns/1ps
`default_nettype none

`include "mem_tile_config.svh"

module mem_bank_column (
  input  wire logic                                      clk_i,
  input  wire logic                                      arst_n_i,
  input  wire logic                                      req_i,
  input  wire logic                                      we_i,
  input  wire logic [mem_tile_pkg::sel_width-1:0]        row_sel_i,
  input  wire logic [mem_tile_pkg::row_addr_width-1:0]   row_addr_i,
  input  wire logic [`MEM_LANE_WIDTH-1:0]                wdata_i,
  input  wire logic [mem_tile_pkg::lane_be_width-1:0]    be_i,
  output logic      [`MEM_LANE_WIDTH-1:0]                rdata_o
);

  logic [`MEM_LANE_WIDTH-1:0]         macro_rdata [`MEM_NUM_ROWS];
  logic [mem_tile_pkg::sel_width-1:0] row_sel_q;

  //////////////////////////////////////////////////////////////////////
  // Macro row
  //////////////////////////////////////////////////////////////////////

  for (genvar r = 0; r < `MEM_NUM_ROWS; r++) begin : gen_macros
    localparam logic [mem_tile_pkg::sel_width-1:0] row_id = r;

    logic row_hit;

    assign row_hit = (row_sel_i == row_id);

    sram_macro #(
      .num_words_p (`MEM_ROW_WORDS),
      .data_width_p(`MEM_LANE_WIDTH)
    ) i_macro (
      .clk_i  (clk_i),
      .req_i  (req_i && row_hit),
      .we_i   (we_i && row_hit),
      .addr_i (row_addr_i),
      .wdata_i(wdata_i),
      .be_i   (be_i),
      .rdata_o(macro_rdata[r])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Read-data selection
  //////////////////////////////////////////////////////////////////////

  // Remember which macro was read, writes leave the select alone
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      row_sel_q <= '0;
    end else if (req_i && !we_i) begin
      row_sel_q <= row_sel_i;
    end
  end

  assign rdata_o = macro_rdata[row_sel_q];

endmodule

`default_nettype wire

/* sram_macro.sv */
// Single-port SRAM macro
// Byte-enabled writes, reads land in an output register one cycle
// after the request edge

`timescale 1ns/1ps
`default_nettype none

module sram_macro #(
  parameter int unsigned num_words_p  = 64,
  parameter int unsigned data_width_p = 32
) (
  input  wire logic                          clk_i,
  input  wire logic                          req_i,
  input  wire logic                          we_i,
  input  wire logic [$clog2(num_words_p)-1:0] addr_i,
  input  wire logic [data_width_p-1:0]       wdata_i,
  input  wire logic [data_width_p/8-1:0]     be_i,
  output logic      [data_width_p-1:0]       rdata_o
);

  localparam int unsigned num_bytes = data_width_p / 8;

  logic [data_width_p-1:0] mem_q [num_words_p];
  logic [data_width_p-1:0] rdata_q;

  //////////////////////////////////////////////////////////////////////
  // Storage array
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < num_bytes; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Output register only moves on a read
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* mem_tile_pkg.sv */
// Memory tile package
// Widths derived from the configuration and the two views of the
// requester byte address

`default_nettype none

`include "mem_tile_config.svh"

package mem_tile_pkg;

  localparam int unsigned word_width     = `MEM_NUM_LANES * `MEM_LANE_WIDTH;
  localparam int unsigned offset_width   = $clog2(word_width / 8);
  localparam int unsigned row_addr_width = $clog2(`MEM_ROW_WORDS);
  localparam int unsigned sel_width      = $clog2(`MEM_NUM_ROWS);
  localparam int unsigned lane_be_width  = `MEM_LANE_WIDTH / 8;

  // Bits above the decoded range, zero for any address inside the memory
  localparam int unsigned high_width =
      `MEM_ADDR_WIDTH - sel_width - row_addr_width - offset_width;

  typedef struct packed {
    logic [high_width-1:0]     high;
    logic [sel_width-1:0]      macro_sel;
    logic [row_addr_width-1:0] row_addr;
    logic [offset_width-1:0]   offset;
  } mem_addr_fields_t;

  // Flat view for the range check, field view for bank decode
  typedef union packed {
    logic [`MEM_ADDR_WIDTH-1:0] flat;
    mem_addr_fields_t           fields;
  } mem_addr_u;

endpackage

`default_nettype wire

/* mem_tile_config.svh */
// Memory tile configuration
// Sizes of the banked SRAM: lane columns, macro rows per column,
// lane data width, words per macro and the byte address width

`ifndef MEM_TILE_CONFIG_SVH
`define MEM_TILE_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Data word layout
//////////////////////////////////////////////////////////////////////

// Lane columns that make up one data word
`define MEM_NUM_LANES 2

// Data bits carried by one lane
`define MEM_LANE_WIDTH 32

//////////////////////////////////////////////////////////////////////
// Storage depth
//////////////////////////////////////////////////////////////////////

// SRAM macros stacked in each lane column
`define MEM_NUM_ROWS 4

// Words held by a single macro
`define MEM_ROW_WORDS 64

// Byte address seen by the requester
`define MEM_ADDR_WIDTH 16

`endif
